//--- cabinet_io_top.f
hw/cabinet_pkg.sv
hw/settings_regs.sv
hw/control_mapper.sv
hw/strobe_gen.sv
hw/video_out.sv
hw/cabinet_io_top.sv
verification/cabinet_io_checker.sv
verification/cabinet_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cabinet glue testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --assert -j 0 --top-module cabinet_io_tb \
    -f cabinet_io_top.f -o cabinet_io_sim; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench can report them
output=$(./obj_dir/cabinet_io_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

//--- verification/cabinet_io_tb.sv
/*
  directed testbench for the cabinet glue top level
  wishbone register tests, rom download flag, port mapping
  strobe periods and video output stage
  lfsr stimulus, compare tasks, watchdog and summary
*/

`timescale 1ns/1ps
`default_nettype none

module cabinet_io_tb;

  import cabinet_pkg::*;

  localparam int clk_period = 8;
  localparam int reset_cycles = 8;
  localparam int cpu_div = 10;
  localparam int sound_div = 44;
  localparam int pixel_div = 8;

  // rough cycle budget per test, the watchdog allows twice the sum
  localparam int bus_op_cycles = 6;
  localparam int key_cycles = 5;
  localparam int strobe_window = 2 * sound_div + 4;
  localparam int video_steps = 14;
  localparam int readback_cycles = 29 * bus_op_cycles + 4;
  localparam int rom_cycles = 5 * bus_op_cycles + 3;
  localparam int normal_cycles = 4 * bus_op_cycles + 16 * key_cycles;
  localparam int diagonal_cycles = 2 * bus_op_cycles + 17 * key_cycles;
  localparam int strobe_cycles = reset_cycles + 2 + strobe_window;
  localparam int video_cycles = video_steps * (2 * (pixel_div + 1) + 2);
  localparam int total_cycles = reset_cycles + 2 + readback_cycles + rom_cycles
    + normal_cycles + diagonal_cycles + strobe_cycles + video_cycles;
  localparam int watchdog_cycles = 2 * total_cycles;

  logic         clk_40;
  logic         reset;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  wb_addr_t     wb_adr;
  wb_data_t     wb_dat_w;
  wb_data_t     wb_dat_r;
  logic         wb_ack;
  dip_t         dip_switch;
  logic         rom_init;
  key_t         key;
  switch_port_t switch_port;
  joy_port_t    joy_port;
  logic         cpu_ce;
  logic         sound_ce;
  video_t       video_in;
  rgb_t         video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  // internal strobe, not on the top-level ports
  logic         pixel_ce;

  int           errors = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;
  int unsigned  assert_failures;
  logic [15:0]  lfsr_state = 16'd34218;

  cabinet_io_top #(
    .cpu_div   (cpu_div),
    .sound_div (sound_div),
    .pixel_div (pixel_div)
  ) cabinet_io_top_inst (
    .clk_40      (clk_40),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .dip_switch  (dip_switch),
    .rom_init    (rom_init),
    .key         (key),
    .switch_port (switch_port),
    .joy_port    (joy_port),
    .cpu_ce      (cpu_ce),
    .sound_ce    (sound_ce),
    .video_in    (video_in),
    .video_rgb   (video_rgb),
    .video_de    (video_de),
    .video_hs    (video_hs),
    .video_vs    (video_vs)
  );

  assign pixel_ce = cabinet_io_top_inst.pixel_ce;

  initial begin
    clk_40 = 1'b0;
    forever #(clk_period / 2) clk_40 = ~clk_40;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr, taps 16 14 13 11, one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    logic        out_bit;
    value = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 16'hB400;
      end
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  task automatic apply_reset;
    @(posedge clk_40);
    reset <= 1'b1;
    repeat (reset_cycles) @(posedge clk_40);
    reset <= 1'b0;
  endtask

  // one classic cycle, drop stb at the ack edge
  task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat_w,
                           output wb_data_t dat_r);
    int   waited;
    logic acked;
    waited = 0;
    acked = 1'b0;
    dat_r = '0;
    @(posedge clk_40);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat_w;
    while (!acked && waited < 4) begin
      @(negedge clk_40);
      waited++;
      if (wb_ack) begin
        acked = 1'b1;
        dat_r = wb_dat_r;
      end
    end
    @(posedge clk_40);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked) begin
      errors++;
      $display("no wishbone ack within 4 cycles for address %h at %0d ns", adr, $time);
    end
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t discard;
    bus_cycle(1'b1, adr, dat, discard);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    bus_cycle(1'b0, adr, 32'h0, dat);
  endtask

  // key reaches the ports three edges after the driving edge
  task automatic drive_key(input key_t k);
    @(posedge clk_40);
    key <= k;
    repeat (3) @(posedge clk_40);
    @(negedge clk_40);
  endtask

  task automatic wait_pixel_ce;
    int waited;
    waited = 0;
    @(negedge clk_40);
    while (!pixel_ce && waited < 2 * pixel_div) begin
      @(negedge clk_40);
      waited++;
    end
    if (!pixel_ce) begin
      errors++;
      $display("pixel strobe missing for %0d cycles at %0d ns", 2 * pixel_div, $time);
    end
  endtask

  // change video_in right after one strobe, check after the next
  task automatic apply_pixel(input rgb_t rgb, input logic hblank, input logic vblank,
                             input logic hs, input logic vs);
    wait_pixel_ce();
    @(posedge clk_40);
    video_in <= '{rgb: rgb, hblank: hblank, vblank: vblank, hs: hs, vs: vs};
    wait_pixel_ce();
    @(posedge clk_40);
    @(negedge clk_40);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // expected values and compares
  ////////////////////////////////////////////////////////////////////////////

  function automatic switch_port_t expect_switch(input key_t k, input logic test_mode);
    switch_port_t s;
    s = '0;
    s.test1   = k.face_a;
    s.test2_n = ~test_mode;
    s.coin1   = k.face_select;
    s.start2  = k.face_x;
    s.start1  = k.face_start;
    return s;
  endfunction

  function automatic joy_port_t expect_joy(input key_t k, input logic diagonal);
    joy_port_t j;
    j = '0;
    if (diagonal) begin
      j.down  = k.dpad_down & k.dpad_left;
      j.up    = k.dpad_right & k.dpad_up;
      j.left  = k.dpad_up & k.dpad_left;
      j.right = k.dpad_right & k.dpad_down;
    end else begin
      j.down  = k.dpad_down;
      j.up    = k.dpad_up;
      j.left  = k.dpad_left;
      j.right = k.dpad_right;
    end
    return j;
  endfunction

  task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dip(input dip_t got, input dip_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_switch(input switch_port_t got, input switch_port_t exp,
                              input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_joy(input joy_port_t got, input joy_port_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_video(input logic de, input rgb_t rgb, input logic hs,
                             input logic vs, input string what);
    check_bit(video_de, de, {what, " video_de"});
    check_rgb(video_rgb, rgb, {what, " video_rgb"});
    check_bit(video_hs, hs, {what, " video_hs"});
    check_bit(video_vs, vs, {what, " video_vs"});
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_readback;
    int       start;
    wb_data_t mode_word;
    wb_data_t dip_word;
    wb_data_t diag_word;
    wb_data_t got;
    start = errors;
    for (int i = 0; i < 4; i++) begin
      mode_word = random_bits(32);
      dip_word = random_bits(32);
      diag_word = random_bits(32);
      wb_write(reg_test_mode, mode_word);
      wb_write(reg_dip_bank, dip_word);
      wb_write(reg_diagonal, diag_word);
      @(negedge clk_40);
      check_dip(dip_switch, dip_t'(dip_word[7:0]), "dip_switch output");
      wb_read(reg_test_mode, got);
      check_data(got, {31'h0, mode_word[0]}, "test mode readback");
      wb_read(reg_dip_bank, got);
      check_data(got, {24'h0, dip_word[7:0]}, "dip bank readback");
      wb_read(reg_diagonal, got);
      check_data(got, {31'h0, diag_word[0]}, "diagonal readback");
    end
    // holes in the map read as zero
    wb_read(8'h04, got);
    check_data(got, 32'h0, "unmapped read 0x04");
    wb_read(8'h55, got);
    check_data(got, 32'h0, "unmapped read 0x55");
    wb_read(8'hFF, got);
    check_data(got, 32'h0, "unmapped read 0xff");
    wb_write(reg_diagonal, 32'h0);
    wb_write(reg_test_mode, 32'h0);
    report_test("register readback", start);
  endtask

  task automatic test_rom_flag;
    int       start;
    wb_data_t got;
    start = errors;
    @(negedge clk_40);
    check_bit(rom_init, 1'b0, "rom_init after reset");
    wb_write(reg_load_start, random_bits(32));
    @(negedge clk_40);
    check_bit(rom_init, 1'b1, "rom_init after load start");
    wb_read(reg_load_start, got);
    check_data(got, 32'h1, "download flag readback set");
    wb_read(reg_load_done, got);
    check_data(got, 32'h0, "load done register read");
    wb_write(reg_load_done, random_bits(32));
    @(negedge clk_40);
    check_bit(rom_init, 1'b0, "rom_init after load done");
    wb_read(reg_load_start, got);
    check_data(got, 32'h0, "download flag readback clear");
    report_test("rom download flag", start);
  endtask

  task automatic test_normal_map;
    int       start;
    wb_data_t rnd;
    key_t     k;
    start = errors;
    wb_write(reg_diagonal, 32'h0);
    for (int tm = 0; tm < 2; tm++) begin
      wb_write(reg_test_mode, (tm == 1) ? 32'h1 : 32'h0);
      for (int i = 0; i < 8; i++) begin
        rnd = random_bits(16);
        k = key_t'(rnd[15:0]);
        drive_key(k);
        check_switch(switch_port, expect_switch(k, tm == 1), "switch port");
        check_joy(joy_port, expect_joy(k, 1'b0), "straight joystick port");
      end
    end
    wb_write(reg_test_mode, 32'h0);
    report_test("normal mapping", start);
  endtask

  task automatic test_diagonal_map;
    int       start;
    wb_data_t rnd;
    key_t     k;
    logic [3:0] dpad_sets [5];
    start = errors;
    // each pair alone, then all four held
    dpad_sets = '{4'b0110, 4'b1001, 4'b0101, 4'b1010, 4'b1111};
    wb_write(reg_diagonal, 32'h1);
    for (int i = 0; i < 17; i++) begin
      rnd = random_bits(16);
      if (i < 5) begin
        rnd[3:0] = dpad_sets[i];
      end
      k = key_t'(rnd[15:0]);
      drive_key(k);
      check_joy(joy_port, expect_joy(k, 1'b1), "diagonal joystick port");
      check_switch(switch_port, expect_switch(k, 1'b0), "switch port in diagonal mode");
    end
    wb_write(reg_diagonal, 32'h0);
    report_test("diagonal mapping", start);
  endtask

  // cycle c counts edges after the released reset
  task automatic test_strobes;
    int start;
    start = errors;
    apply_reset();
    for (int c = 1; c <= strobe_window; c++) begin
      @(posedge clk_40);
      @(negedge clk_40);
      check_bit(cpu_ce, (c % cpu_div) == 0, $sformatf("cpu_ce in cycle %0d", c));
      check_bit(sound_ce, (c % sound_div) == 0, $sformatf("sound_ce in cycle %0d", c));
      check_bit(pixel_ce, (c % pixel_div) == 0, $sformatf("pixel_ce in cycle %0d", c));
    end
    report_test("strobe periods", start);
  endtask

  task automatic test_video;
    int       start;
    wb_data_t rnd;
    rgb_t     colour;
    rgb_t     shown;
    start = errors;
    shown = '0;
    for (int i = 0; i < 5; i++) begin
      rnd = random_bits(24);
      colour = rgb_t'(rnd[23:0]);
      apply_pixel(colour, 1'b0, 1'b0, 1'b0, 1'b0);
      shown = colour;
      check_video(1'b1, shown, 1'b0, 1'b0, "visible pixel");
    end
    // blanking drops de, colour keeps the last visible value
    rnd = random_bits(24);
    apply_pixel(rgb_t'(rnd[23:0]), 1'b1, 1'b0, 1'b0, 1'b0);
    check_video(1'b0, shown, 1'b0, 1'b0, "hblank");
    rnd = random_bits(24);
    apply_pixel(rgb_t'(rnd[23:0]), 1'b0, 1'b1, 1'b0, 1'b0);
    check_video(1'b0, shown, 1'b0, 1'b0, "vblank");
    // sync edges, one pulse per rising edge
    apply_pixel(shown, 1'b0, 1'b0, 1'b1, 1'b0);
    check_video(1'b1, shown, 1'b1, 1'b0, "hs rising");
    apply_pixel(shown, 1'b0, 1'b0, 1'b1, 1'b0);
    check_video(1'b1, shown, 1'b0, 1'b0, "hs held high");
    apply_pixel(shown, 1'b0, 1'b0, 1'b0, 1'b0);
    check_video(1'b1, shown, 1'b0, 1'b0, "hs low");
    apply_pixel(shown, 1'b0, 1'b0, 1'b0, 1'b1);
    check_video(1'b1, shown, 1'b0, 1'b1, "vs rising");
    apply_pixel(shown, 1'b0, 1'b0, 1'b0, 1'b1);
    check_video(1'b1, shown, 1'b0, 1'b0, "vs held high");
    apply_pixel(shown, 1'b0, 1'b0, 1'b0, 1'b0);
    check_video(1'b1, shown, 1'b0, 1'b0, "vs low");
    apply_pixel(shown, 1'b0, 1'b0, 1'b1, 1'b1);
    check_video(1'b1, shown, 1'b1, 1'b1, "hs and vs rising together");
    report_test("video output", start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    key      = '0;
    video_in = '0;
    apply_reset();
    test_readback();
    test_rom_flag();
    test_normal_map();
    test_diagonal_map();
    test_strobes();
    test_video();
    assert_failures = cabinet_io_top_inst.cabinet_io_checker_inst.failures;
    $display("summary: %0d tests passed, %0d failed, %0d check errors, %0d assertion failures",
             tests_passed, tests_failed, errors, assert_failures);
    if (errors == 0 && tests_failed == 0 && assert_failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/cabinet_io_checker.sv
/*
  concurrent assertions for the cabinet glue top level
  wishbone ack rules, single-cycle clock-enable strobes
  bound into cabinet_io_top
*/

`timescale 1ns/1ps
`default_nettype none

module cabinet_io_checker (
  input logic clk_40,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic cpu_ce,
  input logic sound_ce,
  input logic pixel_ce
);

  // failed assertions, read by the testbench at the end of the run
  int unsigned failures = 0;

  logic [2:0] strobes;

  assign strobes = {cpu_ce, sound_ce, pixel_ce};

  ////////////////////////////////////////////////////////////////////////////
  // wishbone handshake
  ////////////////////////////////////////////////////////////////////////////

  // master holds cyc and stb through the ack cycle
  ack_with_request: assert property (
    @(posedge clk_40) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb)
  ) else begin
    failures++;
    $error("wishbone ack raised without cyc and stb");
  end

  // fixed one-cycle latency, ack lasts one cycle
  ack_single_cycle: assert property (
    @(posedge clk_40) disable iff (reset) wb_ack |=> !wb_ack
  ) else begin
    failures++;
    $error("wishbone ack held for two cycles");
  end

  ////////////////////////////////////////////////////////////////////////////
  // strobes
  ////////////////////////////////////////////////////////////////////////////

  // every enable is one clk_40 cycle wide
  strobe_single_cycle: assert property (
    @(posedge clk_40) disable iff (reset) (strobes & $past(strobes)) == 3'b000
  ) else begin
    failures++;
    $error("clock-enable strobe high for two cycles");
  end

endmodule

bind cabinet_io_top cabinet_io_checker cabinet_io_checker_inst (
  .clk_40   (clk_40),
  .reset    (reset),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .cpu_ce   (cpu_ce),
  .sound_ce (sound_ce),
  .pixel_ce (pixel_ce)
);

`default_nettype wire

//--- hw/cabinet_io_top.sv
/*
  cabinet glue top level
  settings slave, controller mapper, strobe generator, video output
*/

`timescale 1ns/1ps
`default_nettype none

module cabinet_io_top #(
  parameter int unsigned cpu_div   = cabinet_pkg::default_cpu_div,
  parameter int unsigned sound_div = cabinet_pkg::default_sound_div,
  parameter int unsigned pixel_div = cabinet_pkg::default_pixel_div
) (
  input  logic                      clk_40,
  input  logic                      reset,
  // wishbone slave
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  cabinet_pkg::wb_addr_t     wb_adr,
  input  cabinet_pkg::wb_data_t     wb_dat_w,
  output cabinet_pkg::wb_data_t     wb_dat_r,
  output logic                      wb_ack,
  // to the game board
  output cabinet_pkg::dip_t         dip_switch,
  output logic                      rom_init,
  input  cabinet_pkg::key_t         key,
  output cabinet_pkg::switch_port_t switch_port,
  output cabinet_pkg::joy_port_t    joy_port,
  output logic                      cpu_ce,
  output logic                      sound_ce,
  // video
  input  cabinet_pkg::video_t       video_in,
  output cabinet_pkg::rgb_t         video_rgb,
  output logic                      video_de,
  output logic                      video_hs,
  output logic                      video_vs
);

  import cabinet_pkg::*;

  settings_t settings;
  logic      pixel_ce;

  assign dip_switch = settings.dip;

  settings_regs settings_regs_inst (
    .clk_40   (clk_40),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .settings (settings),
    .rom_init (rom_init)
  );

  control_mapper control_mapper_inst (
    .clk_40      (clk_40),
    .reset       (reset),
    .key         (key),
    .settings    (settings),
    .switch_port (switch_port),
    .joy_port    (joy_port)
  );

  strobe_gen #(
    .cpu_div   (cpu_div),
    .sound_div (sound_div),
    .pixel_div (pixel_div)
  ) strobe_gen_inst (
    .clk_40   (clk_40),
    .reset    (reset),
    .cpu_ce   (cpu_ce),
    .sound_ce (sound_ce),
    .pixel_ce (pixel_ce)
  );

  video_out video_out_inst (
    .clk_40    (clk_40),
    .reset     (reset),
    .pixel_ce  (pixel_ce),
    .video_in  (video_in),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

`default_nettype wire

//--- hw/video_out.sv
/*
  video output stage on pixel strobes
  colour capture outside blanking, data enable
  rising-edge pulses from the board syncs
*/

`timescale 1ns/1ps
`default_nettype none

module video_out (
  input  logic                clk_40,
  input  logic                reset,
  input  logic                pixel_ce,
  input  cabinet_pkg::video_t video_in,
  output cabinet_pkg::rgb_t   video_rgb,
  output logic                video_de,
  output logic                video_hs,
  output logic                video_vs
);

  import cabinet_pkg::*;

  // sync levels seen at the previous pixel strobe
  logic hs_prev;
  logic vs_prev;
  logic active;

  // visible area, neither blank set
  assign active = !(video_in.hblank || video_in.vblank);

  ////////////////////////////////////////////////////////////////////////////
  // pixel pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40) begin
    if (reset) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else if (pixel_ce) begin
      video_de <= active;
      // colour holds its last visible value through blanking
      if (active) begin
        video_rgb <= video_in.rgb;
      end
      // one-pixel pulse on each sync rising edge
      video_hs <= video_in.hs && !hs_prev;
      video_vs <= video_in.vs && !vs_prev;
      hs_prev  <= video_in.hs;
      vs_prev  <= video_in.vs;
    end
  end

endmodule

`default_nettype wire

//--- hw/strobe_gen.sv
/*
  clock-enable strobes for the cpu, sound and pixel domains
  one modulo counter per strobe, all on clk_40
*/

`timescale 1ns/1ps
`default_nettype none

module strobe_gen #(
  parameter int unsigned cpu_div   = 10,
  parameter int unsigned sound_div = 44,
  parameter int unsigned pixel_div = 8
) (
  input  logic clk_40,
  input  logic reset,
  output logic cpu_ce,
  output logic sound_ce,
  output logic pixel_ce
);

  localparam int unsigned num_strobes = 3;
  localparam int unsigned div_list [num_strobes] = '{cpu_div, sound_div, pixel_div};
  // shared counter width, wide enough for the largest ratio
  localparam int unsigned max_div = (cpu_div > sound_div) ?
    ((cpu_div > pixel_div) ? cpu_div : pixel_div) :
    ((sound_div > pixel_div) ? sound_div : pixel_div);
  localparam int unsigned cnt_w = $clog2(max_div + 1);

  logic [cnt_w-1:0]       count [num_strobes];
  logic [num_strobes-1:0] strobe;

  for (genvar i = 0; i < num_strobes; i++) begin : g_div
    localparam logic [cnt_w-1:0] last = cnt_w'(div_list[i] - 1);

    // strobe registered on the wrap, first one on cycle n after reset
    always_ff @(posedge clk_40) begin
      if (reset) begin
        count[i]  <= '0;
        strobe[i] <= 1'b0;
      end else if (count[i] == last) begin
        count[i]  <= '0;
        strobe[i] <= 1'b1;
      end else begin
        count[i]  <= count[i] + 1'b1;
        strobe[i] <= 1'b0;
      end
    end
  end

  assign cpu_ce   = strobe[0];
  assign sound_ce = strobe[1];
  assign pixel_ce = strobe[2];

endmodule

`default_nettype wire

//--- hw/control_mapper.sv
/*
  player 1 key synchronizer and cabinet port mapping
  switch port from face buttons and the test-mode setting
  joystick port, straight or diagonal combined directions
*/

`timescale 1ns/1ps
`default_nettype none

module control_mapper (
  input  logic                      clk_40,
  input  logic                      reset,
  input  cabinet_pkg::key_t         key,
  input  cabinet_pkg::settings_t    settings,
  output cabinet_pkg::switch_port_t switch_port,
  output cabinet_pkg::joy_port_t    joy_port
);

  import cabinet_pkg::*;

  // three-stage synchronizer for the host key word
  key_t key_meta;
  key_t key_mid;
  key_t key_sync;

  always_ff @(posedge clk_40) begin
    if (reset) begin
      key_meta <= '0;
      key_mid  <= '0;
      key_sync <= '0;
    end else begin
      key_meta <= key;
      key_mid  <= key_meta;
      key_sync <= key_mid;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // switch port
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    switch_port.test1   = key_sync.face_a;
    // active low on the board
    switch_port.test2_n = !settings.test_mode;
    switch_port.spare   = 2'b00;
    switch_port.coin1   = key_sync.face_select;
    // no second coin slot on the pad
    switch_port.coin2   = 1'b0;
    switch_port.start2  = key_sync.face_x;
    switch_port.start1  = key_sync.face_start;
  end

  ////////////////////////////////////////////////////////////////////////////
  // joystick port
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    joy_port.spare = 4'b0000;
    if (settings.diagonal) begin
      // rotated stick, each line needs two pad directions held
      joy_port.down  = key_sync.dpad_down && key_sync.dpad_left;
      joy_port.up    = key_sync.dpad_right && key_sync.dpad_up;
      joy_port.left  = key_sync.dpad_up && key_sync.dpad_left;
      joy_port.right = key_sync.dpad_right && key_sync.dpad_down;
    end else begin
      // straight copy of the dpad
      joy_port.down  = key_sync.dpad_down;
      joy_port.up    = key_sync.dpad_up;
      joy_port.left  = key_sync.dpad_left;
      joy_port.right = key_sync.dpad_right;
    end
  end

endmodule

`default_nettype wire

//--- hw/settings_regs.sv
/*
  wishbone classic slave for the cabinet settings
  test mode, diagonal option, dip bank, rom download flag
  single-cycle ack, combinational read mux
*/

`timescale 1ns/1ps
`default_nettype none

module settings_regs (
  input  logic                 clk_40,
  input  logic                 reset,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  cabinet_pkg::wb_addr_t wb_adr,
  input  cabinet_pkg::wb_data_t wb_dat_w,
  output cabinet_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  output cabinet_pkg::settings_t settings,
  output logic                 rom_init
);

  import cabinet_pkg::*;

  // request is live while the master holds cyc and stb
  logic request;
  // write commits in the ack cycle, master still holds its signals
  logic write_en;

  assign request  = wb_cyc && wb_stb;
  assign write_en = wb_ack && request && wb_we;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // ack one cycle after the request, never twice in a row
  always_ff @(posedge clk_40) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= request && !wb_ack;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40) begin
    if (reset) begin
      settings <= '0;
      rom_init <= 1'b0;
    end else if (write_en) begin
      case (wb_adr)
        // single-bit switches from bit 0
        reg_test_mode: begin
          settings.test_mode <= wb_dat_w[0];
        end
        reg_diagonal: begin
          settings.diagonal <= wb_dat_w[0];
        end
        // whole dip bank from the low byte
        reg_dip_bank: begin
          settings.dip <= dip_t'(wb_dat_w[7:0]);
        end
        // download window, data ignored
        reg_load_start: begin
          rom_init <= 1'b1;
        end
        reg_load_done: begin
          rom_init <= 1'b0;
        end
        default: begin
          // unmapped, write dropped
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  // sampled by the master in the ack cycle
  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      reg_test_mode: begin
        wb_dat_r[0] = settings.test_mode;
      end
      reg_diagonal: begin
        wb_dat_r[0] = settings.diagonal;
      end
      reg_dip_bank: begin
        wb_dat_r[7:0] = settings.dip;
      end
      // download flag readback
      reg_load_start: begin
        wb_dat_r[0] = rom_init;
      end
      // reg_load_done and unmapped read as zero
      default: begin
        wb_dat_r = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/cabinet_pkg.sv
/*
  shared types and constants for the cabinet glue layer
  wishbone address and data words, settings register map
  controller key, dip, settings, port and video structs
  default strobe divider ratios
*/

`default_nettype none

package cabinet_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // wishbone bus
  ////////////////////////////////////////////////////////////////////////////

  // byte address, only the low byte is decoded
  typedef logic [7:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // settings register map
  localparam wb_addr_t reg_test_mode  = 8'h00;
  localparam wb_addr_t reg_dip_bank   = 8'h10;
  localparam wb_addr_t reg_diagonal   = 8'h90;
  localparam wb_addr_t reg_load_start = 8'hA0;
  localparam wb_addr_t reg_load_done  = 8'hA4;

  ////////////////////////////////////////////////////////////////////////////
  // controller and cabinet ports
  ////////////////////////////////////////////////////////////////////////////

  // controller key word, msb first so dpad_up lands on bit 0
  typedef struct packed {
    logic face_start;
    logic face_select;
    logic trig_r3;
    logic trig_l3;
    logic trig_r2;
    logic trig_l2;
    logic trig_r1;
    logic trig_l1;
    logic face_y;
    logic face_x;
    logic face_b;
    logic face_a;
    logic dpad_right;
    logic dpad_left;
    logic dpad_down;
    logic dpad_up;
  } key_t;

  // dip bank, switch 1 on the msb
  typedef struct packed {
    logic dip_1;
    logic dip_2;
    logic dip_3;
    logic dip_4;  // free play
    logic dip_5;  // auto round advance
    logic dip_6;  // cabinet type, 0 upright
    logic dip_7;  // kicker
    logic dip_8;  // attract-mode sound
  } dip_t;

  typedef struct packed {
    logic test_mode;
    logic diagonal;
    dip_t dip;
  } settings_t;

  // switch port as the game board reads it
  typedef struct packed {
    logic       test1;
    logic       test2_n;  // low enters test mode
    logic [1:0] spare;
    logic       coin1;
    logic       coin2;
    logic       start2;
    logic       start1;
  } switch_port_t;

  typedef struct packed {
    logic [3:0] spare;
    logic       down;
    logic       up;
    logic       left;
    logic       right;
  } joy_port_t;

  ////////////////////////////////////////////////////////////////////////////
  // video
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    rgb_t rgb;
    logic hblank;
    logic vblank;
    logic hs;
    logic vs;
  } video_t;

  // strobe ratios against clk_40
  localparam int unsigned default_cpu_div   = 10;
  localparam int unsigned default_sound_div = 44;
  localparam int unsigned default_pixel_div = 8;

endpackage

`default_nettype wire
